//--- src/core_cfg.svh
// Core configuration macros
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Width of data words and addresses
`define CORE_XLEN 32

// Number of architectural registers
`define CORE_REG_COUNT 32

// PC loaded while reset is held
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- src/riscv_isa_pkg.sv
// RV32I instruction set types
`include "core_cfg.svh"

package riscv_isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [31:0]           instr_t;
    typedef logic [2:0]            funct3_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_t;

    // Branch conditions
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // Load and store access sizes
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    // ALU operation fields of OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_source_t;

endpackage

//--- src/core_ctrl_pkg.sv
// Core control select types
`include "core_cfg.svh"

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_control_t;

    // Second ALU operand
    typedef enum logic {
        ALU_SOURCE_RD,
        ALU_SOURCE_IMM
    } alu_source_t;

    typedef enum logic [1:0] {
        WB_SOURCE_ALU_RESULT,
        WB_SOURCE_MEM_READ,
        WB_SOURCE_PC_PLUS_FOUR,
        WB_SOURCE_SECOND_ADD
    } wb_source_t;

    typedef enum logic {
        SOURCE_PC_PLUS_4,
        SOURCE_PC_SECOND_ADD
    } pc_source_t;

    // Operands of the target adder
    typedef enum logic [1:0] {
        SECOND_ADDER_SOURCE_PC,
        SECOND_ADDER_SOURCE_RD,
        SECOND_ADDER_SOURCE_ZERO
    } second_add_source_t;

endpackage

//--- src/ctrl_if.sv
// Decode to datapath control bundle
interface ctrl_if;
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    alu_control_t       alu_control;
    alu_source_t        alu_source;
    imm_source_t        imm_source;
    second_add_source_t second_add_source;
    wb_source_t         write_back_source;
    logic               reg_write;

    modport decode (
        output alu_control,
        output alu_source,
        output imm_source,
        output second_add_source,
        output write_back_source,
        output reg_write
    );

    modport exec (
        input alu_control,
        input alu_source,
        input imm_source,
        input second_add_source,
        input write_back_source,
        input reg_write
    );
endinterface

//--- src/alu.sv
// Arithmetic and logic unit
module alu (
    input  core_ctrl_pkg::alu_control_t i_alu_control,
    input  riscv_isa_pkg::word_t        i_src1,
    input  riscv_isa_pkg::word_t        i_src2,
    output riscv_isa_pkg::word_t        o_result,
    output logic                        o_zero,
    output logic                        o_last_bit
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_alu_control)
            ALU_ADD:  o_result = i_src1 + i_src2;
            ALU_SUB:  o_result = i_src1 - i_src2;
            ALU_AND:  o_result = i_src1 & i_src2;
            ALU_OR:   o_result = i_src1 | i_src2;
            ALU_XOR:  o_result = i_src1 ^ i_src2;
            ALU_SLT:  o_result = word_t'($signed(i_src1) < $signed(i_src2));
            ALU_SLTU: o_result = word_t'(i_src1 < i_src2);
            ALU_SLL:  o_result = i_src1 << shamt;
            ALU_SRL:  o_result = i_src1 >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_src1) >>> shamt);
            default:  o_result = '0;
        endcase
    end

    // Branches read equality from zero and order from the compare bit
    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];
endmodule

//--- src/regfile.sv
// Integer register file
`include "core_cfg.svh"

module regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  riscv_isa_pkg::reg_addr_t i_raddr1,
    input  riscv_isa_pkg::reg_addr_t i_raddr2,
    input  riscv_isa_pkg::reg_addr_t i_waddr,
    input  logic                     i_we,
    input  riscv_isa_pkg::word_t     i_wdata,
    output riscv_isa_pkg::word_t     o_rdata1,
    output riscv_isa_pkg::word_t     o_rdata2
);
    import riscv_isa_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];
endmodule

//--- src/core_control.sv
// Instruction decoder and branch resolution
module core_control (
    input  logic                      rst_n,
    input  riscv_isa_pkg::instr_t     i_instr,
    input  logic                      i_alu_zero,
    input  logic                      i_alu_last_bit,
    ctrl_if.decode                    ctrl,
    output core_ctrl_pkg::pc_source_t o_pc_source,
    output logic                      o_mem_we,
    output logic                      o_mem_re
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    alt_op;
    logic    reg_write;
    logic    mem_we;
    logic    mem_re;
    logic    branch;
    logic    jump;
    logic    taken;

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    // Bit 30 selects sub and sra
    assign alt_op = i_instr[30];

    function automatic alu_control_t decode_alu(input funct3_t f3, input logic alt,
                                                input logic is_reg);
        alu_control_t op;
        case (f3)
            F3_ADD_SUB: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // Unknown opcodes fall through as a no-op
        ctrl.alu_control       = ALU_ADD;
        ctrl.alu_source        = ALU_SOURCE_RD;
        ctrl.imm_source        = IMM_I;
        ctrl.second_add_source = SECOND_ADDER_SOURCE_PC;
        ctrl.write_back_source = WB_SOURCE_ALU_RESULT;
        reg_write = 1'b0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        case (opcode)
            OPCODE_LUI: begin
                ctrl.imm_source        = IMM_U;
                ctrl.second_add_source = SECOND_ADDER_SOURCE_ZERO;
                ctrl.write_back_source = WB_SOURCE_SECOND_ADD;
                reg_write = 1'b1;
            end
            OPCODE_JAL: begin
                ctrl.imm_source        = IMM_J;
                ctrl.write_back_source = WB_SOURCE_PC_PLUS_FOUR;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            OPCODE_JALR: begin
                ctrl.second_add_source = SECOND_ADDER_SOURCE_RD;
                ctrl.write_back_source = WB_SOURCE_PC_PLUS_FOUR;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            OPCODE_BRANCH: begin
                ctrl.imm_source  = IMM_B;
                // Equality tests subtract, ordering tests compare
                ctrl.alu_control = (funct3[2]) ? ALU_SLT : ALU_SUB;
                branch = 1'b1;
            end
            OPCODE_LOAD: begin
                ctrl.alu_source        = ALU_SOURCE_IMM;
                ctrl.write_back_source = WB_SOURCE_MEM_READ;
                reg_write = 1'b1;
                mem_re    = 1'b1;
            end
            OPCODE_STORE: begin
                ctrl.imm_source = IMM_S;
                ctrl.alu_source = ALU_SOURCE_IMM;
                mem_we = 1'b1;
            end
            OPCODE_OP_IMM: begin
                ctrl.alu_source  = ALU_SOURCE_IMM;
                ctrl.alu_control = decode_alu(funct3, alt_op, 1'b0);
                reg_write = 1'b1;
            end
            OPCODE_OP: begin
                ctrl.alu_control = decode_alu(funct3, alt_op, 1'b1);
                reg_write = 1'b1;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = i_alu_zero;
            F3_BNE:  taken = !i_alu_zero;
            F3_BLT:  taken = i_alu_last_bit;
            F3_BGE:  taken = !i_alu_last_bit;
            default: taken = 1'b0;
        endcase
    end

    assign o_pc_source = (jump || (branch && taken)) ? SOURCE_PC_SECOND_ADD : SOURCE_PC_PLUS_4;

    // Strobes stay quiet while reset is held
    assign ctrl.reg_write = reg_write && rst_n;
    assign o_mem_we       = mem_we && rst_n;
    assign o_mem_re       = mem_re && rst_n;
endmodule

//--- src/pc_unit.sv
// Program counter
`include "core_cfg.svh"

module pc_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_stall,
    input  core_ctrl_pkg::pc_source_t i_pc_source,
    input  riscv_isa_pkg::word_t      i_second_add,
    output riscv_isa_pkg::word_t      o_pc,
    output riscv_isa_pkg::word_t      o_pc_plus_four
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t pc_next;

    assign o_pc_plus_four = o_pc + word_t'(4);

    always_comb begin
        // Stall wins over any jump or branch
        if (i_stall) begin
            pc_next = o_pc;
        end else if (i_pc_source == SOURCE_PC_SECOND_ADD) begin
            pc_next = i_second_add;
        end else begin
            pc_next = o_pc_plus_four;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= `CORE_RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end
endmodule

//--- src/datapath.sv
// Execute datapath around ALU and registers
module datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  riscv_isa_pkg::instr_t i_instr,
    input  riscv_isa_pkg::word_t  i_pc,
    input  riscv_isa_pkg::word_t  i_pc_plus_four,
    input  logic                  i_stall,
    input  riscv_isa_pkg::word_t  i_load_data,
    ctrl_if.exec                  ctrl,
    output riscv_isa_pkg::word_t  o_alu_result,
    output riscv_isa_pkg::word_t  o_store_src,
    output riscv_isa_pkg::word_t  o_second_add,
    output logic                  o_alu_zero,
    output logic                  o_alu_last_bit
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t imm;
    word_t rdata1;
    word_t alu_src2;
    word_t wb_data;

    // Immediate by instruction format
    always_comb begin
        case (ctrl.imm_source)
            IMM_I: imm = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_S: imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                          i_instr[11:8], 1'b0};
            IMM_J: imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                          i_instr[30:21], 1'b0};
            IMM_U: imm = {i_instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    assign alu_src2 = (ctrl.alu_source == ALU_SOURCE_IMM) ? imm : o_store_src;

    // Target adder for branches, jumps and lui
    always_comb begin
        case (ctrl.second_add_source)
            SECOND_ADDER_SOURCE_PC:   o_second_add = i_pc + imm;
            // jalr drops the target's low bit
            SECOND_ADDER_SOURCE_RD:   o_second_add = (rdata1 + imm) & ~word_t'(1);
            SECOND_ADDER_SOURCE_ZERO: o_second_add = imm;
            default:                  o_second_add = '0;
        endcase
    end

    always_comb begin
        case (ctrl.write_back_source)
            WB_SOURCE_MEM_READ:     wb_data = i_load_data;
            WB_SOURCE_PC_PLUS_FOUR: wb_data = i_pc_plus_four;
            WB_SOURCE_SECOND_ADD:   wb_data = o_second_add;
            default:                wb_data = o_alu_result;
        endcase
    end

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_raddr1 (i_instr[19:15]),
        .i_raddr2 (i_instr[24:20]),
        .i_waddr  (i_instr[11:7]),
        .i_we     (ctrl.reg_write && !i_stall),
        .i_wdata  (wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (o_store_src)
    );

    alu u_alu (
        .i_alu_control (ctrl.alu_control),
        .i_src1        (rdata1),
        .i_src2        (alu_src2),
        .o_result      (o_alu_result),
        .o_zero        (o_alu_zero),
        .o_last_bit    (o_alu_last_bit)
    );
endmodule

//--- src/load_store_unit.sv
// Byte lane shaping for loads and stores
module load_store_unit (
    input  riscv_isa_pkg::word_t   i_addr,
    input  riscv_isa_pkg::word_t   i_store_data,
    input  riscv_isa_pkg::funct3_t i_funct3,
    input  riscv_isa_pkg::word_t   i_mem_rdata,
    output logic [3:0]             o_byte_en,
    output riscv_isa_pkg::word_t   o_mem_wdata,
    output riscv_isa_pkg::word_t   o_load_data
);
    import riscv_isa_pkg::*;

    logic [4:0] bit_shift;
    word_t      lane_data;

    // Misaligned addresses still shift by the low bits
    assign bit_shift = {i_addr[1:0], 3'b000};
    assign lane_data = i_mem_rdata >> bit_shift;

    // Store side
    always_comb begin
        o_mem_wdata = i_store_data << bit_shift;
        case (i_funct3)
            F3_BYTE: o_byte_en = 4'b0001 << i_addr[1:0];
            F3_HALF: o_byte_en = 4'b0011 << i_addr[1:0];
            F3_WORD: begin
                o_byte_en   = 4'b1111;
                o_mem_wdata = i_store_data;
            end
            default: o_byte_en = 4'b0000;
        endcase
    end

    // Load side
    always_comb begin
        case (i_funct3)
            F3_BYTE:   o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            F3_HALF:   o_load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            F3_BYTE_U: o_load_data = {24'b0, lane_data[7:0]};
            F3_HALF_U: o_load_data = {16'b0, lane_data[15:0]};
            default:   o_load_data = i_mem_rdata;
        endcase
    end
endmodule

//--- src/holy_core.sv
// Single-cycle RV32I core
module holy_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  riscv_isa_pkg::instr_t i_imem_rdata,
    input  riscv_isa_pkg::word_t  i_dmem_rdata,
    input  logic                  i_mem_stall,
    output riscv_isa_pkg::word_t  o_imem_addr,
    output riscv_isa_pkg::word_t  o_dmem_addr,
    output riscv_isa_pkg::word_t  o_dmem_wdata,
    output logic [3:0]            o_dmem_byte_en,
    output logic                  o_dmem_we,
    output logic                  o_dmem_re
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      pc_plus_four;
    word_t      second_add;
    word_t      store_src;
    word_t      load_data;
    pc_source_t pc_source;
    logic       alu_zero;
    logic       alu_last_bit;

    ctrl_if u_ctrl_if ();

    core_control u_core_control (
        .rst_n          (rst_n),
        .i_instr        (i_imem_rdata),
        .i_alu_zero     (alu_zero),
        .i_alu_last_bit (alu_last_bit),
        .ctrl           (u_ctrl_if.decode),
        .o_pc_source    (pc_source),
        .o_mem_we       (o_dmem_we),
        .o_mem_re       (o_dmem_re)
    );

    // PC doubles as the fetch address
    pc_unit u_pc_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_stall        (i_mem_stall),
        .i_pc_source    (pc_source),
        .i_second_add   (second_add),
        .o_pc           (o_imem_addr),
        .o_pc_plus_four (pc_plus_four)
    );

    // ALU result doubles as the data address
    datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_instr        (i_imem_rdata),
        .i_pc           (o_imem_addr),
        .i_pc_plus_four (pc_plus_four),
        .i_stall        (i_mem_stall),
        .i_load_data    (load_data),
        .ctrl           (u_ctrl_if.exec),
        .o_alu_result   (o_dmem_addr),
        .o_store_src    (store_src),
        .o_second_add   (second_add),
        .o_alu_zero     (alu_zero),
        .o_alu_last_bit (alu_last_bit)
    );

    load_store_unit u_load_store_unit (
        .i_addr       (o_dmem_addr),
        .i_store_data (store_src),
        .i_funct3     (i_imem_rdata[14:12]),
        .i_mem_rdata  (i_dmem_rdata),
        .o_byte_en    (o_dmem_byte_en),
        .o_mem_wdata  (o_dmem_wdata),
        .o_load_data  (load_data)
    );
endmodule

//--- verif/tb_holy_core.sv
// Single-cycle core testbench
`include "core_cfg.svh"

module tb_holy_core;
    import riscv_isa_pkg::*;

    localparam int PERIOD          = 100;
    localparam int TOTAL_INSTR     = 300;
    localparam int STALL_ALLOWANCE = 4;
    localparam int RUN_COUNT       = 6;

    logic       clk;
    logic       rst_n;
    instr_t     i_imem_rdata;
    word_t      i_dmem_rdata;
    logic       i_mem_stall;
    word_t      o_imem_addr;
    word_t      o_dmem_addr;
    word_t      o_dmem_wdata;
    logic [3:0] o_dmem_byte_en;
    logic       o_dmem_we;
    logic       o_dmem_re;

    word_t      rom [256];
    word_t      ram [256];
    int         prog_len;
    word_t      end_pc;
    word_t      pc_trace [$];
    logic [3:0] be_log [$];
    int         error_count;
    int         check_count;

    holy_core i_holy_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_imem_rdata   (i_imem_rdata),
        .i_dmem_rdata   (i_dmem_rdata),
        .i_mem_stall    (i_mem_stall),
        .o_imem_addr    (o_imem_addr),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_dmem_byte_en (o_dmem_byte_en),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_re      (o_dmem_re)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Combinational instruction reads, data reads only while requested
    assign i_imem_rdata = rom[o_imem_addr[9:2]];
    assign i_dmem_rdata = o_dmem_re ? ram[o_dmem_addr[9:2]] : 'x;

    always @(posedge clk) begin
        if (rst_n && o_dmem_we && !i_mem_stall) begin
            be_log.push_back(o_dmem_byte_en);
            for (int l = 0; l < 4; l++) begin
                if (o_dmem_byte_en[l]) begin
                    ram[o_dmem_addr[9:2]][8*l +: 8] <= o_dmem_wdata[8*l +: 8];
                end
            end
        end
    end

    task automatic check(input word_t got, input word_t exp, input string msg);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                     input funct3_t f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPCODE_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input int rs1, input funct3_t f3,
                                     input int rd, input opcode_t op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                     input funct3_t f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                     input funct3_t f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPCODE_JAL};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), OPCODE_LUI};
    endfunction

    task automatic emit(input instr_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    function automatic word_t here();
        return word_t'(prog_len * 4);
    endfunction

    // Fresh ROM of self-loops and a RAM pattern over the whole address
    task automatic begin_program();
        for (int i = 0; i < 256; i++) begin
            rom[i] = enc_j(21'd0, 0);
            ram[i] = (i * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
        end
        prog_len = 0;
        be_log.delete();
    endtask

    // Reset is already low on entry
    task automatic reset_core();
        @(posedge clk);
        @(negedge clk);
        check(word_t'(o_dmem_we), 0, "write strobe during reset");
        check(word_t'(o_dmem_re), 0, "read strobe during reset");
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(o_imem_addr, `CORE_RESET_PC, "PC after reset");
    endtask

    // Ends the program with a self-loop and runs it there
    task automatic run_program(input logic stall_on);
        logic  prev_stall;
        word_t held_pc;
        end_pc = here();
        emit(enc_j(21'd0, 0));
        reset_core();
        pc_trace.delete();
        pc_trace.push_back(o_imem_addr);
        prev_stall = 1'b0;
        held_pc    = o_imem_addr;
        while (o_imem_addr != end_pc || prev_stall) begin
            @(posedge clk);
            i_mem_stall <= stall_on && ($urandom % 3 == 0);
            @(negedge clk);
            if (prev_stall) begin
                check(o_imem_addr, held_pc, "PC hold during stall");
            end else begin
                pc_trace.push_back(o_imem_addr);
            end
            prev_stall = i_mem_stall;
            held_pc    = o_imem_addr;
        end
        @(posedge clk);
        i_mem_stall <= 1'b0;
        // Core stays in reset while the next program is loaded
        rst_n       <= 1'b0;
        @(negedge clk);
    endtask

    function automatic word_t next_pc_after(input word_t pc);
        for (int i = 0; i + 1 < pc_trace.size(); i++) begin
            if (pc_trace[i] == pc) begin
                return pc_trace[i + 1];
            end
        end
        return 'x;
    endfunction

    // funct3 of arithmetic op k, register forms 0..9, immediate forms 10..18
    function automatic funct3_t op_f3(input int k);
        case (k)
            0, 1, 10: return 3'b000;
            2, 15:    return 3'b111;
            3, 14:    return 3'b110;
            4, 13:    return 3'b100;
            5, 11:    return 3'b010;
            6, 12:    return 3'b011;
            7, 16:    return 3'b001;
            default:  return 3'b101;
        endcase
    endfunction

    function automatic word_t arith_ref(input int k, input word_t a, input word_t b,
                                        input logic [11:0] imm, input logic [4:0] sh,
                                        input logic [19:0] u);
        word_t bi;
        bi = {{20{imm[11]}}, imm};
        case (k)
            0:  return a + b;
            1:  return a - b;
            2:  return a & b;
            3:  return a | b;
            4:  return a ^ b;
            5:  return word_t'($signed(a) < $signed(b));
            6:  return word_t'(a < b);
            7:  return a << b[4:0];
            8:  return a >> b[4:0];
            9:  return $signed(a) >>> b[4:0];
            10: return a + bi;
            11: return word_t'($signed(a) < $signed(bi));
            12: return word_t'(a < bi);
            13: return a ^ bi;
            14: return a | bi;
            15: return a & bi;
            16: return a << sh;
            17: return a >> sh;
            18: return $signed(a) >>> sh;
            default: return {u, 12'b0};
        endcase
    endfunction

    task automatic test_arith(input word_t a, input word_t b, input logic [11:0] imm,
                              input logic [4:0] sh, input logic [19:0] u, input logic stall_on);
        logic [11:0] field;
        begin_program();
        ram[128] = a;
        ram[129] = b;
        // Load first so the read strobe would be live during reset
        emit(enc_i(12'h200, 0, F3_WORD, 2, OPCODE_LOAD));
        emit(enc_i(12'h204, 0, F3_WORD, 3, OPCODE_LOAD));
        emit(enc_i(12'h200, 0, 3'b000, 1, OPCODE_OP_IMM));
        for (int k = 0; k < 20; k++) begin
            if (k < 10) begin
                emit(enc_r((k == 1 || k == 9) ? 7'h20 : 7'h00, 3, 2, op_f3(k), 4));
            end else if (k < 19) begin
                field = (k < 16) ? imm : {(k == 18) ? 7'h20 : 7'h00, sh};
                emit(enc_i(field, 2, op_f3(k), 4, OPCODE_OP_IMM));
            end else begin
                emit(enc_u(u, 4));
            end
            emit(enc_s(12'(12'h100 + 4 * k), 4, 1, F3_WORD));
        end
        run_program(stall_on);
        for (int k = 0; k < 20; k++) begin
            check(ram[192 + k], arith_ref(k, a, b, imm, sh, u), $sformatf("arith op %0d", k));
        end
    endtask

    function automatic word_t store_lanes(input word_t old, input word_t data, input int off,
                                          input int size);
        word_t r;
        r = old;
        for (int l = 0; l < 4; l++) begin
            if (l >= off && l < off + size) begin
                r[8*l +: 8] = data[8*(l-off) +: 8];
            end
        end
        return r;
    endfunction

    // Lanes covered by an access that fit inside the word
    function automatic logic [3:0] lane_mask(input int off, input int size);
        logic [3:0] m;
        for (int l = 0; l < 4; l++) begin
            m[l] = (l >= off && l < off + size);
        end
        return m;
    endfunction

    function automatic word_t load_ref(input word_t w, input int off, input funct3_t f3);
        word_t s;
        s = w >> (8 * off);
        case (f3)
            F3_BYTE:   return {{24{s[7]}}, s[7:0]};
            F3_HALF:   return {{16{s[15]}}, s[15:0]};
            F3_BYTE_U: return {24'b0, s[7:0]};
            F3_HALF_U: return {16'b0, s[15:0]};
            default:   return w;
        endcase
    endfunction

    task automatic test_memory();
        funct3_t f3s [4] = '{F3_BYTE, F3_BYTE_U, F3_HALF, F3_HALF_U};
        word_t   old [8];
        int      k;
        begin_program();
        ram[129] = 32'hC3B2_A190;
        ram[130] = 32'h8F1E_B27C;
        for (int o = 0; o < 8; o++) begin
            old[o] = ram[144 + o];
        end
        emit(enc_i(12'h200, 0, 3'b000, 1, OPCODE_OP_IMM));
        emit(enc_i(12'h004, 1, F3_WORD, 2, OPCODE_LOAD));
        // Byte stores, then half stores, one word per offset
        for (int o = 0; o < 4; o++) begin
            emit(enc_s(12'(12'h040 + 5 * o), 2, 1, F3_BYTE));
        end
        for (int o = 0; o < 4; o++) begin
            emit(enc_s(12'(12'h060 + 5 * o), 2, 1, F3_HALF));
            old[4 + o] = ram[152 + o];
        end
        k = 0;
        foreach (f3s[f]) begin
            for (int o = 0; o < 4; o++) begin
                emit(enc_i(12'(8 + o), 1, f3s[f], 5, OPCODE_LOAD));
                emit(enc_s(12'(12'h100 + 4 * k), 5, 1, F3_WORD));
                k++;
            end
        end
        emit(enc_i(12'h008, 1, F3_WORD, 5, OPCODE_LOAD));
        emit(enc_s(12'(12'h100 + 4 * k), 5, 1, F3_WORD));
        run_program(1'b0);
        check(word_t'(be_log.size()), 25, "store count");
        for (int o = 0; o < 4; o++) begin
            check(ram[144 + o], store_lanes(old[o], 32'hC3B2_A190, o, 1), "sb lanes");
            check(ram[152 + o], store_lanes(old[4 + o], 32'hC3B2_A190, o, 2), "sh lanes");
            check(word_t'(be_log[o]), word_t'(lane_mask(o, 1)), "sb byte enable");
            check(word_t'(be_log[4 + o]), word_t'(lane_mask(o, 2)), "sh byte enable");
        end
        k = 0;
        foreach (f3s[f]) begin
            for (int o = 0; o < 4; o++) begin
                check(ram[192 + k], load_ref(32'h8F1E_B27C, o, f3s[f]), "sub-word load");
                k++;
            end
        end
        check(ram[192 + k], 32'h8F1E_B27C, "lw");
    endtask

    task automatic test_control();
        funct3_t f3s [8] = '{F3_BEQ, F3_BEQ, F3_BNE, F3_BNE, F3_BLT, F3_BLT, F3_BGE, F3_BGE};
        int      ra [8] = '{2, 2, 2, 2, 3, 2, 2, 3};
        int      rb [8] = '{2, 3, 3, 2, 2, 3, 3, 2};
        word_t   old [12];
        word_t   va;
        word_t   vb;
        logic    taken;
        word_t   jal_pc;
        word_t   jalr_pc;
        word_t   tgt;
        begin_program();
        for (int i = 0; i < 12; i++) begin
            old[i] = ram[192 + i];
        end
        emit(enc_i(12'h200, 0, 3'b000, 1, OPCODE_OP_IMM));
        emit(enc_i(12'd5, 0, 3'b000, 2, OPCODE_OP_IMM));
        emit(enc_i(12'hFFD, 0, 3'b000, 3, OPCODE_OP_IMM));
        emit(enc_i(12'd1, 0, 3'b000, 6, OPCODE_OP_IMM));
        // Each taken branch skips its marker store
        for (int i = 0; i < 8; i++) begin
            emit(enc_b(13'd8, rb[i], ra[i], f3s[i]));
            emit(enc_s(12'(12'h100 + 4 * i), 6, 1, F3_WORD));
        end
        jal_pc = here();
        emit(enc_j(21'd8, 7));
        emit(enc_s(12'h120, 6, 1, F3_WORD));
        emit(enc_s(12'h124, 7, 1, F3_WORD));
        tgt = here() + 12;
        emit(enc_i(tgt[11:0], 0, 3'b000, 8, OPCODE_OP_IMM));
        jalr_pc = here();
        emit(enc_i(12'h000, 8, 3'b000, 9, OPCODE_JALR));
        emit(enc_s(12'h128, 6, 1, F3_WORD));
        emit(enc_s(12'h12C, 9, 1, F3_WORD));
        run_program(1'b0);
        for (int i = 0; i < 8; i++) begin
            va = (ra[i] == 2) ? 32'd5 : 32'hFFFF_FFFD;
            vb = (rb[i] == 2) ? 32'd5 : 32'hFFFF_FFFD;
            case (f3s[i])
                F3_BEQ:  taken = (va == vb);
                F3_BNE:  taken = (va != vb);
                F3_BLT:  taken = ($signed(va) < $signed(vb));
                default: taken = ($signed(va) >= $signed(vb));
            endcase
            check(ram[192 + i], taken ? old[i] : 32'd1, $sformatf("branch case %0d", i));
        end
        check(ram[200], old[8], "jal skipped store");
        check(ram[201], jal_pc + 4, "jal link");
        check(ram[202], old[10], "jalr skipped store");
        check(ram[203], jalr_pc + 4, "jalr link");
        check(next_pc_after(jal_pc), jal_pc + 8, "jal target");
        check(next_pc_after(jalr_pc), tgt, "jalr target");
    endtask

    task automatic test_reset();
        begin_program();
        // Store first so the write strobe would be live during reset
        emit(enc_s(12'h104, 0, 0, F3_WORD));
        emit(enc_i(12'h200, 0, 3'b000, 1, OPCODE_OP_IMM));
        emit(enc_i(12'h055, 0, 3'b000, 0, OPCODE_OP_IMM));
        emit(enc_s(12'h100, 0, 1, F3_WORD));
        run_program(1'b0);
        check(ram[192], 32'd0, "x0 stays zero");
    endtask

    initial begin
        #(PERIOD * (TOTAL_INSTR * STALL_ALLOWANCE + 10 * RUN_COUNT));
        $display("Timeout: the core never reached the final loop of its program");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] u;
        rst_n       = 1'b0;
        i_mem_stall = 1'b0;
        error_count = 0;
        check_count = 0;
        void'($urandom(76));
        test_reset();
        test_arith(32'h8000_0000, 32'h0000_0003, 12'h800, 5'd31, 20'hFFFFF, 1'b0);
        a   = $urandom;
        b   = $urandom;
        imm = 12'($urandom);
        sh  = 5'($urandom);
        u   = 20'($urandom);
        test_arith(a, b, imm, sh, u, 1'b0);
        test_memory();
        test_control();
        // Same random program under stall pulses
        test_arith(a, b, imm, sh, u, 1'b1);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

//--- sim.f
+incdir+src
src/riscv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/ctrl_if.sv
src/alu.sv
src/regfile.sv
src/core_control.sv
src/pc_unit.sv
src/datapath.sv
src/load_store_unit.sv
src/holy_core.sv
verif/tb_holy_core.sv
